/* cpu8085_pkg.sv */
package cpu8085_pkg;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] addr_t;
	typedef logic [2:0]  reg_sel_t; // opcode register field

	localparam int FETCH_TSTATES = 4;
	localparam int MEM_TSTATES   = 3;

	localparam addr_t    RESET_PC = 16'h0000;
	localparam reg_sel_t REG_M    = 3'b110; // memory through hl
	localparam reg_sel_t REG_A    = 3'b111;

	typedef struct packed {
		logic s;
		logic z;
		logic p;
		logic cy;
	} flags_t;

	typedef enum logic [1:0] {MC_RESET, MC_FETCH, MC_MEM_READ, MC_MEM_WRITE} mcycle_e;

	typedef enum logic [4:0] {
		I_MVI, I_LXI, I_LDA, I_STA,
		I_MOV_RR, I_MOV_RM, I_MOV_MR,
		I_ADC, I_SBB, I_ANA, I_CMP, I_ACI,
		I_JMP, I_JC, I_CALL, I_RET,
		I_ILLEGAL
	} instr_e;

	typedef enum logic [1:0] {ALU_ADC, ALU_SBB, ALU_ANA, ALU_CMP} alu_op_e;

	typedef enum logic [2:0] {AS_PC, AS_HL, AS_WZ, AS_SP, AS_SP_MINUS1} addr_src_e;

	typedef enum logic [1:0] {DS_REG, DS_ACC, DS_PC_HIGH, DS_PC_LOW} data_src_e;

	typedef struct packed {
		instr_e     instr;
		reg_sel_t   dst;
		reg_sel_t   src;
		logic [1:0] rp;
		byte_t      data;       // last byte read from the bus
		logic       wr_reg;
		logic       wr_acc_alu;
		logic       wr_temp;
		logic       wr_z;       // wz low byte
		logic       wr_w;       // wz high byte
		logic       pc_inc;
		logic       pc_load;
		logic       sp_inc;
		logic       sp_dec;
		logic       sp_load;
		logic       byte_idx;   // 0 low operand, 1 high operand
		addr_src_e  addr_src;
		data_src_e  data_src;
	} cpu_ctrl_t;

	typedef struct packed {
		logic ale;
		logic rd;
		logic wr;
	} bus_phase_t;

endpackage

/* cycle_sequencer.sv */
`timescale 1ns/1ps

module cycle_sequencer (
	input  logic                    clk,
	input  logic                    reset_all,
	input  cpu8085_pkg::byte_t      i_data,
	input  cpu8085_pkg::flags_t     i_flags,
	output cpu8085_pkg::cpu_ctrl_t  o_ctrl,
	output cpu8085_pkg::bus_phase_t o_bus
);
	import cpu8085_pkg::*;

	mcycle_e    mcycle;
	logic [1:0] tstate;     // 0 is T1
	logic [2:0] mc_idx;     // 0 is the opcode fetch
	logic [2:0] mc_count;
	byte_t      opcode;
	byte_t      data_q;
	instr_e     instr;
	reg_sel_t   dst_f;
	reg_sel_t   src_f;
	logic       last_t;
	logic       t3;

	function automatic mcycle_e mem_kind(instr_e ins, logic [2:0] idx);
		if ((ins == I_MOV_MR) || (ins == I_STA && idx == 3'd3) || (ins == I_CALL && idx >= 3'd3))
			return MC_MEM_WRITE;
		return MC_MEM_READ;
	endfunction

	assign dst_f = opcode[5:3];
	assign src_f = opcode[2:0];

	always_comb begin
		casez (opcode)
			8'b00??_?110: instr = (dst_f == REG_M) ? I_ILLEGAL : I_MVI;
			8'b00??_0001: instr = I_LXI;
			8'h3a:        instr = I_LDA;
			8'h32:        instr = I_STA;
			8'b01??_????: begin
				if (dst_f == REG_M && src_f == REG_M)
					instr = I_ILLEGAL; // hlt
				else if (dst_f == REG_M)
					instr = I_MOV_MR;
				else if (src_f == REG_M)
					instr = I_MOV_RM;
				else
					instr = I_MOV_RR;
			end
			8'b10??_????: begin
				case (dst_f)
					3'b001:  instr = I_ADC;
					3'b011:  instr = I_SBB;
					3'b100:  instr = I_ANA;
					3'b111:  instr = I_CMP;
					default: instr = I_ILLEGAL;
				endcase
				if (src_f == REG_M)
					instr = I_ILLEGAL;
			end
			8'hce:   instr = I_ACI;
			8'hc3:   instr = I_JMP;
			8'hda:   instr = I_JC;
			8'hcd:   instr = I_CALL;
			8'hc9:   instr = I_RET;
			default: instr = I_ILLEGAL;
		endcase
	end

	// machine cycles after the fetch
	always_comb begin
		case (instr)
			I_MVI, I_ACI, I_MOV_RM, I_MOV_MR: mc_count = 3'd1;
			I_LXI, I_JMP, I_JC, I_RET:        mc_count = 3'd2;
			I_LDA, I_STA:                     mc_count = 3'd3;
			I_CALL:                           mc_count = 3'd4;
			default:                          mc_count = 3'd0;
		endcase
	end

	assign last_t = (mcycle == MC_FETCH) ? (tstate == 2'(FETCH_TSTATES - 1))
	                                     : (tstate == 2'(MEM_TSTATES - 1));
	assign t3 = (mcycle != MC_RESET) && (tstate == 2'd2);

	always_ff @(posedge clk or posedge reset_all) begin
		if (reset_all) begin
			mcycle <= MC_RESET;
			tstate <= '0;
			mc_idx <= '0;
			opcode <= 8'h00;
		end else if (mcycle == MC_RESET) begin
			mcycle <= MC_FETCH;
		end else begin
			if (t3 && mcycle == MC_FETCH)
				opcode <= i_data;
			if (last_t) begin
				tstate <= '0;
				if (mc_idx == mc_count) begin
					mcycle <= MC_FETCH;
					mc_idx <= '0;
				end else begin
					mcycle <= mem_kind(instr, mc_idx + 3'd1);
					mc_idx <= mc_idx + 3'd1;
				end
			end else begin
				tstate <= tstate + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (t3 && mcycle != MC_MEM_WRITE)
			data_q <= i_data;
	end

	always_comb begin
		o_bus = '0;
		o_bus.ale = (mcycle != MC_RESET) && (tstate == 2'd0);
		o_bus.rd = (mcycle == MC_FETCH || mcycle == MC_MEM_READ) && (tstate inside {2'd1, 2'd2});
		o_bus.wr = (mcycle == MC_MEM_WRITE) && (tstate inside {2'd1, 2'd2});
	end

	always_comb begin
		o_ctrl = '0;
		o_ctrl.instr = instr;
		o_ctrl.dst = dst_f;
		o_ctrl.src = src_f;
		o_ctrl.rp = opcode[5:4];
		o_ctrl.data = data_q;
		o_ctrl.byte_idx = (mc_idx == 3'd2);
		o_ctrl.addr_src = AS_PC;
		o_ctrl.data_src = DS_REG;
		if (mc_idx != 3'd0) begin
			case (instr)
				I_MOV_RM, I_MOV_MR: o_ctrl.addr_src = AS_HL;
				I_RET:              o_ctrl.addr_src = AS_SP;
				I_CALL: if (mc_idx >= 3'd3) o_ctrl.addr_src = AS_SP_MINUS1;
				I_LDA, I_STA: if (mc_idx == 3'd3) o_ctrl.addr_src = AS_WZ;
				default: ;
			endcase
		end
		if (instr == I_STA)
			o_ctrl.data_src = DS_ACC;
		else if (instr == I_CALL)
			o_ctrl.data_src = (mc_idx == 3'd3) ? DS_PC_HIGH : DS_PC_LOW; // high byte pushed first

		case (mcycle)
			MC_FETCH: begin
				// alu result of the previous opcode lands in T1
				if (tstate == 2'd0)
					o_ctrl.wr_acc_alu = instr inside {I_ADC, I_SBB, I_ANA, I_CMP, I_ACI};
				if (tstate == 2'd2)
					o_ctrl.pc_inc = 1'b1;
				if (tstate == 2'd3) begin
					o_ctrl.wr_reg = (instr == I_MOV_RR);
					o_ctrl.wr_temp = instr inside {I_ADC, I_SBB, I_ANA, I_CMP};
				end
			end
			MC_MEM_READ: if (t3) begin
				o_ctrl.pc_inc = (o_ctrl.addr_src == AS_PC);
				o_ctrl.wr_reg = (instr inside {I_MVI, I_MOV_RM})
				             || (instr == I_LDA && mc_idx == 3'd3)
				             || (instr == I_LXI && opcode[5:4] != 2'b11);
				o_ctrl.sp_load = (instr == I_LXI && opcode[5:4] == 2'b11);
				if (instr inside {I_JMP, I_JC, I_CALL, I_RET, I_LDA, I_STA}) begin
					o_ctrl.wr_z = (mc_idx == 3'd1);
					o_ctrl.wr_w = (mc_idx == 3'd2);
				end
				o_ctrl.sp_inc = (instr == I_RET);
				o_ctrl.pc_load = (mc_idx == 3'd2)
				              && (instr inside {I_JMP, I_RET} || (instr == I_JC && i_flags.cy));
			end
			MC_MEM_WRITE: if (t3 && instr == I_CALL) begin
				o_ctrl.sp_dec = 1'b1;
				o_ctrl.pc_load = (mc_idx == 3'd4);
			end
			default: ;
		endcase
	end

endmodule

/* addr_unit.sv */
`timescale 1ns/1ps

module addr_unit (
	input  logic                   clk,
	input  logic                   reset_all,
	input  cpu8085_pkg::cpu_ctrl_t i_ctrl,
	input  cpu8085_pkg::byte_t     i_data,
	output cpu8085_pkg::addr_t     o_pc,
	output cpu8085_pkg::addr_t     o_sp,
	output cpu8085_pkg::addr_t     o_wz
);
	import cpu8085_pkg::*;

	addr_t pc;
	addr_t sp;
	addr_t wz;

	always_ff @(posedge clk or posedge reset_all) begin
		if (reset_all) begin
			pc <= RESET_PC;
		end else if (i_ctrl.pc_load) begin
			// high byte may arrive on the same edge (jmp, jc, ret)
			if (i_ctrl.wr_w)
				pc <= {i_data, wz[7:0]};
			else
				pc <= wz;
		end else if (i_ctrl.pc_inc) begin
			pc <= pc + 16'd1;
		end
	end

	always_ff @(posedge clk or posedge reset_all) begin
		if (reset_all) begin
			sp <= '0;
		end else if (i_ctrl.sp_load) begin
			if (i_ctrl.byte_idx)
				sp[15:8] <= i_data;
			else
				sp[7:0] <= i_data; // lxi sp, low byte first
		end else if (i_ctrl.sp_inc) begin
			sp <= sp + 16'd1;
		end else if (i_ctrl.sp_dec) begin
			sp <= sp - 16'd1;
		end
	end

	// operand / popped bytes
	always_ff @(posedge clk) begin
		if (i_ctrl.wr_z)
			wz[7:0] <= i_data;
		if (i_ctrl.wr_w)
			wz[15:8] <= i_data;
	end

	assign o_pc = pc;
	assign o_sp = sp;
	assign o_wz = wz;

endmodule

/* reg_alu_unit.sv */
`timescale 1ns/1ps

module reg_alu_unit (
	input  logic                   clk,
	input  logic                   reset_all,
	input  cpu8085_pkg::cpu_ctrl_t i_ctrl,
	input  cpu8085_pkg::byte_t     i_data,
	output cpu8085_pkg::flags_t    o_flags,
	output cpu8085_pkg::addr_t     o_hl,
	output cpu8085_pkg::byte_t     o_reg_data,
	output cpu8085_pkg::byte_t     o_acc
);
	import cpu8085_pkg::*;

	byte_t      regs [8]; // b c d e h l - a
	byte_t      temp;
	flags_t     flags;
	alu_op_e    alu_op;
	byte_t      operand;
	logic       cy_in;
	logic [8:0] alu_sum;
	reg_sel_t   wr_sel;
	byte_t      wr_data;

	always_comb begin
		case (i_ctrl.instr)
			I_SBB:   alu_op = ALU_SBB;
			I_ANA:   alu_op = ALU_ANA;
			I_CMP:   alu_op = ALU_CMP;
			default: alu_op = ALU_ADC; // adc, aci
		endcase
	end

	assign operand = (i_ctrl.instr == I_ACI) ? i_ctrl.data : temp;
	assign cy_in = (alu_op == ALU_ADC || alu_op == ALU_SBB) ? flags.cy : 1'b0;

	always_comb begin
		case (alu_op)
			ALU_ADC: alu_sum = {1'b0, o_acc} + {1'b0, operand} + 9'(cy_in);
			ALU_ANA: alu_sum = {1'b0, o_acc & operand};
			default: alu_sum = {1'b0, o_acc} - {1'b0, operand} - 9'(cy_in); // bit 8 is borrow
		endcase
	end

	// lxi picks the pair half, low byte comes first
	assign wr_sel = (i_ctrl.instr == I_LXI) ? {i_ctrl.rp, ~i_ctrl.byte_idx} : i_ctrl.dst;
	assign wr_data = (i_ctrl.instr == I_MOV_RR) ? regs[i_ctrl.src] : i_data;

	always_ff @(posedge clk) begin
		if (i_ctrl.wr_reg)
			regs[wr_sel] <= wr_data;
		else if (i_ctrl.wr_acc_alu && alu_op != ALU_CMP)
			regs[REG_A] <= alu_sum[7:0];
		if (i_ctrl.wr_temp)
			temp <= regs[i_ctrl.src];
	end

	always_ff @(posedge clk or posedge reset_all) begin
		if (reset_all) begin
			flags <= '0;
		end else if (i_ctrl.wr_acc_alu) begin
			flags.s <= alu_sum[7];
			flags.z <= (alu_sum[7:0] == 8'h00);
			flags.p <= ~^alu_sum[7:0]; // even parity
			flags.cy <= alu_sum[8];    // always 0 for ana
		end
	end

	assign o_flags = flags;
	assign o_hl = {regs[3'd4], regs[3'd5]};
	assign o_reg_data = regs[i_ctrl.src];
	assign o_acc = regs[REG_A];

endmodule

/* bus_mux.sv */
`timescale 1ns/1ps

module bus_mux (
	input  cpu8085_pkg::cpu_ctrl_t  i_ctrl,
	input  cpu8085_pkg::bus_phase_t i_bus,
	input  cpu8085_pkg::addr_t      i_pc,
	input  cpu8085_pkg::addr_t      i_sp,
	input  cpu8085_pkg::addr_t      i_wz,
	input  cpu8085_pkg::addr_t      i_hl,
	input  cpu8085_pkg::byte_t      i_reg_data,
	input  cpu8085_pkg::byte_t      i_acc,
	output cpu8085_pkg::byte_t      o_addr_hi,
	output cpu8085_pkg::byte_t      o_ad,
	output logic                    o_ad_oe,
	output logic                    o_ale,
	output logic                    o_rd_n,
	output logic                    o_wr_n
);
	import cpu8085_pkg::*;

	addr_t addr;
	byte_t data_out;

	always_comb begin
		case (i_ctrl.addr_src)
			AS_HL:        addr = i_hl;
			AS_WZ:        addr = i_wz;
			AS_SP:        addr = i_sp;
			AS_SP_MINUS1: addr = i_sp - 16'd1; // push slot
			default:      addr = i_pc;
		endcase
	end

	always_comb begin
		case (i_ctrl.data_src)
			DS_ACC:     data_out = i_acc;
			DS_PC_HIGH: data_out = i_pc[15:8];
			DS_PC_LOW:  data_out = i_pc[7:0];
			default:    data_out = i_reg_data;
		endcase
	end

	assign o_addr_hi = addr[15:8];
	assign o_ad = i_bus.ale ? addr[7:0] : data_out; // low address only in T1
	assign o_ad_oe = i_bus.ale | i_bus.wr;
	assign o_ale = i_bus.ale;
	assign o_rd_n = ~i_bus.rd;
	assign o_wr_n = ~i_bus.wr;

endmodule

/* cpu8085_top.sv */
`timescale 1ns/1ps

module cpu8085_top (
	input  logic               clk,
	input  logic               reset_all,
	input  cpu8085_pkg::byte_t i_ad,
	output cpu8085_pkg::byte_t o_ad,
	output logic               o_ad_oe,
	output cpu8085_pkg::byte_t o_addr_hi,
	output logic               o_ale,
	output logic               o_rd_n,
	output logic               o_wr_n
);
	import cpu8085_pkg::*;

	cpu_ctrl_t  ctrl;
	bus_phase_t bus_phase;
	flags_t     flags;
	addr_t      pc;
	addr_t      sp;
	addr_t      wz;
	addr_t      hl;
	byte_t      reg_data;
	byte_t      acc;

	cycle_sequencer u_seq (
		.clk       (clk),
		.reset_all (reset_all),
		.i_data    (i_ad),
		.i_flags   (flags),
		.o_ctrl    (ctrl),
		.o_bus     (bus_phase)
	);

	addr_unit u_addr (
		.clk       (clk),
		.reset_all (reset_all),
		.i_ctrl    (ctrl),
		.i_data    (i_ad),
		.o_pc      (pc),
		.o_sp      (sp),
		.o_wz      (wz)
	);

	reg_alu_unit u_regs (
		.clk        (clk),
		.reset_all  (reset_all),
		.i_ctrl     (ctrl),
		.i_data     (i_ad),
		.o_flags    (flags),
		.o_hl       (hl),
		.o_reg_data (reg_data),
		.o_acc      (acc)
	);

	// address and outgoing byte onto the pins
	bus_mux u_mux (
		.i_ctrl     (ctrl),
		.i_bus      (bus_phase),
		.i_pc       (pc),
		.i_sp       (sp),
		.i_wz       (wz),
		.i_hl       (hl),
		.i_reg_data (reg_data),
		.i_acc      (acc),
		.o_addr_hi  (o_addr_hi),
		.o_ad       (o_ad),
		.o_ad_oe    (o_ad_oe),
		.o_ale      (o_ale),
		.o_rd_n     (o_rd_n),
		.o_wr_n     (o_wr_n)
	);

endmodule

/* tb_cpu8085_assertions.sv */
`timescale 1ns/1ps

module tb_cpu8085_assertions (
	input logic clk,
	input logic reset_all,
	input logic i_ale,
	input logic i_rd_n,
	input logic i_wr_n,
	input logic i_ad_oe
);

	// read and write strobes are exclusive
	rd_wr_exclusive: assert property (@(posedge clk) disable iff (reset_all)
		i_rd_n || i_wr_n)
		else $error("rd_n and wr_n low in the same clock");

	ale_outside_strobes: assert property (@(posedge clk) disable iff (reset_all)
		!i_ale || (i_rd_n && i_wr_n))
		else $error("ale high while a strobe is low");

	// cpu drives the bus for the address phase or write data, never against memory
	oe_when_driving: assert property (@(posedge clk) disable iff (reset_all)
		!i_ad_oe || (i_rd_n && (!i_wr_n || i_ale)))
		else $error("ad_oe high outside T1 and write cycles or during a read");

endmodule

bind cpu8085_top tb_cpu8085_assertions u_bus_checks (
	.clk       (clk),
	.reset_all (reset_all),
	.i_ale     (o_ale),
	.i_rd_n    (o_rd_n),
	.i_wr_n    (o_wr_n),
	.i_ad_oe   (o_ad_oe)
);

/* tb_cpu8085.sv */
`timescale 1ns/1ps

module tb_cpu8085;
	import cpu8085_pkg::*;

	localparam int N_ROWS = 12;
	localparam int WAIT_LIMIT = 2000; // clocks per program

	typedef struct packed {
		alu_op_e op;
		byte_t   a;
		byte_t   b;
		logic    cin;
		byte_t   exp_res;
		logic    exp_cy;
	} alu_row_t;

	logic  clk = 1'b0;
	logic  reset_all = 1'b1;
	byte_t i_ad = 8'h00;
	byte_t o_ad;
	logic  o_ad_oe;
	byte_t o_addr_hi;
	logic  o_ale;
	logic  o_rd_n;
	logic  o_wr_n;

	byte_t    mem [65536];
	addr_t    bus_addr = 16'h0000;
	addr_t    log_addr [$];
	byte_t    log_data [$];
	addr_t    exp_addr [$];
	byte_t    exp_data [$];
	logic     wr_n_q = 1'b1;
	int       rd_run = 0;
	addr_t    load_ptr;
	alu_row_t rows [N_ROWS];
	int       seed = 32'h839b;
	int       errors = 0;
	int       timeouts = 0;
	string    test_name;

	cpu8085_top u_dut (
		.clk       (clk),
		.reset_all (reset_all),
		.i_ad      (i_ad),
		.o_ad      (o_ad),
		.o_ad_oe   (o_ad_oe),
		.o_addr_hi (o_addr_hi),
		.o_ale     (o_ale),
		.o_rd_n    (o_rd_n),
		.o_wr_n    (o_wr_n)
	);

	always #50 clk = ~clk;

	task automatic check_byte(input byte_t got, input byte_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns [%s] %s: got %02h, expected %02h",
				$time, test_name, what, got, exp);
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("ERROR %0t ns [%s] %s: got %04h, expected %04h",
				$time, test_name, what, got, exp);
		end
	endtask

	// memory on the multiplexed bus
	always @(negedge clk) begin
		if (reset_all) begin
			log_addr.delete();
			log_data.delete();
			wr_n_q = 1'b1;
			rd_run = 0;
		end else begin
			if (o_ale)
				bus_addr = {o_addr_hi, o_ad}; // low byte only valid in T1
			if (!o_wr_n && wr_n_q) begin
				check_byte({7'd0, o_ad_oe}, 8'd1, "ad_oe with write data");
				log_addr.push_back(bus_addr);
				log_data.push_back(o_ad);
				mem[bus_addr] = o_ad;
			end
			wr_n_q = o_wr_n;
			if (!o_rd_n) begin
				rd_run++;
			end else if (rd_run != 0) begin
				check_byte(byte_t'(rd_run), 8'd2, "rd_n low clocks");
				rd_run = 0;
			end
		end
		i_ad = o_rd_n ? 8'h00 : mem[bus_addr];
	end

	function automatic alu_row_t make_row(alu_op_e op, byte_t a, byte_t b, logic cin);
		alu_row_t row;
		int t;
		row.op = op;
		row.a = a;
		row.b = b;
		row.cin = cin;
		case (op)
			ALU_ADC: t = int'(a) + int'(b) + int'(cin);
			ALU_SBB: t = int'(a) - int'(b) - int'(cin);
			ALU_CMP: t = int'(a) - int'(b);
			default: t = int'(a & b);
		endcase
		row.exp_res = (op == ALU_CMP) ? a : byte_t'(t);
		row.exp_cy = (t > 255) || (t < 0); // carry out or borrow
		return row;
	endfunction

	function automatic byte_t alu_opcode(alu_op_e op);
		case (op)
			ALU_ADC: return 8'h88; // adc b
			ALU_SBB: return 8'h98;
			ALU_ANA: return 8'ha0;
			default: return 8'hb8; // cmp b
		endcase
	endfunction

	task automatic put_op(input byte_t op);
		mem[load_ptr] = op;
		load_ptr++;
	endtask

	task automatic put_op_imm(input byte_t op, input byte_t imm);
		put_op(op);
		put_op(imm);
	endtask

	task automatic put_op_addr(input byte_t op, input addr_t a);
		put_op(op);
		put_op(a[7:0]); // low byte first
		put_op(a[15:8]);
	endtask

	task automatic park();
		put_op_addr(8'hc3, load_ptr); // jmp to itself
	endtask

	task automatic expect_write(input addr_t a, input byte_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic start_test(input string name);
		@(negedge clk);
		reset_all = 1'b1;
		test_name = name;
		for (int a = 0; a < 65536; a++)
			mem[16'(a)] = byte_t'(a ^ (a >> 8) ^ 'h5a);
		load_ptr = 16'h0000;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic run_and_check();
		int n;
		n = 0;
		repeat (3) @(negedge clk);
		// ale, rd_n, wr_n, ad_oe
		check_byte({4'd0, o_ale, o_rd_n, o_wr_n, o_ad_oe}, 8'b0000_0110, "bus pins in reset");
		reset_all = 1'b0;
		while (!o_ale && n < 10) begin
			@(negedge clk);
			n++;
		end
		check_byte(byte_t'(n), 8'd1, "clocks to first ALE");
		check_addr({o_addr_hi, o_ad}, 16'h0000, "first fetch address");
		n = 0;
		while (log_addr.size() < exp_addr.size() && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (log_addr.size() < exp_addr.size()) begin
			timeouts++;
			$display("[%s] timeout, only %0d of %0d memory writes seen",
				test_name, log_addr.size(), exp_addr.size());
		end
		for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++) begin
			check_addr(log_addr[i], exp_addr[i], "write address");
			check_byte(log_data[i], exp_data[i], "write data");
		end
	endtask

	initial begin
		int r;
		rows[0] = make_row(ALU_ADC, 8'hff, 8'h00, 1'b1);
		rows[1] = make_row(ALU_SBB, 8'h00, 8'h01, 1'b0);
		rows[2] = make_row(ALU_ANA, 8'hf0, 8'h3c, 1'b1);
		rows[3] = make_row(ALU_CMP, 8'h10, 8'h20, 1'b0);
		for (int i = 4; i < N_ROWS; i++) begin
			r = $random(seed);
			rows[i] = make_row(alu_op_e'(r[1:0]), byte_t'(r[15:8]), byte_t'(r[23:16]), r[31]);
		end

		for (int i = 0; i < N_ROWS; i++) begin
			start_test($sformatf("alu row %0d", i));
			put_op_imm(8'h3e, rows[i].cin ? 8'hff : 8'h00); // mvi a
			put_op_imm(8'hce, {7'd0, rows[i].cin});          // aci, sets cy
			put_op_imm(8'h3e, rows[i].a);
			put_op_imm(8'h06, rows[i].b);                    // mvi b
			put_op(alu_opcode(rows[i].op));
			put_op_addr(8'h32, 16'h8000);                    // sta
			put_op_addr(8'hda, 16'h0014);                    // jc
			put_op_imm(8'h0e, 8'h00);                        // mvi c
			put_op_addr(8'hc3, 16'h0016);
			put_op_imm(8'h0e, 8'h01);                        // at 0014
			put_op_addr(8'h21, 16'h8001);                    // lxi h
			put_op(8'h71);                                   // mov m,c
			park();
			expect_write(16'h8000, rows[i].exp_res);
			expect_write(16'h8001, {7'd0, rows[i].exp_cy});
			run_and_check();
		end

		start_test("register and indirect moves");
		mem[16'h8100] = 8'ha7;
		put_op_imm(8'h06, 8'h5a);
		put_op(8'h50);                // mov d,b
		put_op_addr(8'h21, 16'h8100);
		put_op(8'h5e);                // mov e,m
		put_op_addr(8'h21, 16'h8110);
		put_op(8'h72);                // mov m,d
		put_op_addr(8'h21, 16'h8111);
		put_op(8'h73);                // mov m,e
		park();
		expect_write(16'h8110, 8'h5a);
		expect_write(16'h8111, 8'ha7);
		run_and_check();

		start_test("load and store");
		mem[16'h8200] = 8'h3c;
		put_op_addr(8'h3a, 16'h8200); // lda
		put_op_addr(8'h32, 16'h8201);
		park();
		expect_write(16'h8201, 8'h3c);
		run_and_check();

		start_test("call and return");
		put_op_addr(8'h31, 16'h9000); // lxi sp
		put_op_addr(8'hcd, 16'h0020); // call, return address 0006
		put_op_addr(8'h32, 16'h8300);
		park();
		load_ptr = 16'h0020;
		put_op_imm(8'h3e, 8'h77);
		put_op(8'hc9);                // ret
		expect_write(16'h8fff, 8'h00);
		expect_write(16'h8ffe, 8'h06);
		expect_write(16'h8300, 8'h77);
		run_and_check();

		$display("errors: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* filelist.f */
cpu8085_pkg.sv
cycle_sequencer.sv
addr_unit.sv
reg_alu_unit.sv
bus_mux.sv
cpu8085_top.sv
tb_cpu8085_assertions.sv
tb_cpu8085.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f filelist.f --top-module tb_cpu8085 -o tb_cpu8085 \
	&& ./obj_dir/tb_cpu8085 > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }

cat sim.log
grep -q "TEST PASSED" sim.log && exit 0 || exit 1
